// ==== r5p_exu.f ====
+incdir+hw
hw/riscv_isa_pkg.sv
hw/r5p_stage.sv
hw/r5p_dec.sv
hw/r5p_alu.sv
hw/r5p_res.sv
hw/r5p_exu.sv
tests/r5p_exu_props.sv
tests/r5p_exu_tb.sv

// ==== tests/r5p_exu_tb.sv ====
// testbench for the integer execute slice
// directed and random issue, reference model, compare process

`timescale 1ns/1ps

module r5p_exu_tb import riscv_isa_pkg::*; ();

  localparam int unsigned N_RAND  = 300;
  localparam int unsigned CYC_MAX = 400;  // ~360 issue cycles plus drain

  typedef struct packed {
    wb_t         wb;
    mem_t        mem;
    logic [31:0] cyc;  // issue cycle
  } exp_t;

  logic        clk;
  logic        rst_n;
  iss_t        iss;
  wb_t         wb;
  mem_t        mem;
  exp_t        exp_q[$];  // expected results in issue order
  int unsigned cyc;
  int unsigned n_mis;
  int unsigned n_other;
  integer      seed;

  xlen_t opa [3] = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0000};  // corner rs1
  xlen_t opb [3] = '{32'h0000_001f, 32'h0000_0000, 32'hffff_ffff};  // corner rs2
  logic [2:0] ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};          // lb lh lw lbu lhu

  r5p_exu r5p_exu_i (.clk(clk), .rst_n(rst_n), .iss(iss), .wb(wb), .mem(mem));

  bind r5p_exu r5p_exu_props props_i (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_MAX) begin
      $display("timeout after %0d cycles, %0d results pending", cyc, exp_q.size());
      $display("errors: %0d mismatches, %0d other", n_mis, n_other + 1);
      $display("Errors found");
      $finish;
    end
  end

  ////////////////////
  // encoders
  ////////////////////

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, rd, opc};  // source indices don't matter here
  endfunction

  function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [2:0] f3);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_AUIPC};
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  function automatic exp_t predict(input iss_t i, input logic [31:0] at);
    exp_t       e;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    xlen_t      a;
    xlen_t      b;
    xlen_t      ii;
    xlen_t      is;
    logic [4:0] sh;
    logic       ok;   // legal encoding
    logic       alu;  // writes a register
    opc = i.ins[6:0];
    f3  = i.ins[14:12];
    f7  = i.ins[31:25];
    ii  = {{20{i.ins[31]}}, i.ins[31:20]};
    is  = {{20{i.ins[31]}}, i.ins[31:25], i.ins[11:7]};
    a   = i.rs1;
    b   = i.rs2;
    ok  = 1'b0;
    alu = 1'b0;
    e   = '0;
    e.cyc    = at;
    e.wb.vld = 1'b1;
    e.wb.rd  = i.ins[11:7];
    case (opc)
      OPC_OP, OPC_OP_IMM: begin
        alu = 1'b1;
        if (opc == OPC_OP) begin
          ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        end else begin
          b  = ii;
          ok = (f3 == 3'd1) ? (f7 == 7'h00) :
               (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        end
        sh = b[4:0];  // RV32 shift amount
        case (f3)
          3'd0: e.wb.dat = (opc == OPC_OP && f7[5]) ? a - b : a + b;
          3'd1: e.wb.dat = a << sh;
          3'd2: e.wb.dat = ($signed(a) < $signed(b));
          3'd3: e.wb.dat = (a < b);
          3'd4: e.wb.dat = a ^ b;
          3'd5: begin
            if (f7[5]) e.wb.dat = $signed(a) >>> sh;
            else e.wb.dat = a >> sh;
          end
          3'd6: e.wb.dat = a | b;
          default: e.wb.dat = a & b;
        endcase
      end
      OPC_AUIPC: begin
        ok       = 1'b1;
        alu      = 1'b1;
        e.wb.dat = i.pc + {i.ins[31:12], 12'h000};
      end
      OPC_LOAD: begin
        ok = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        e.mem.adr = a + ii;
      end
      OPC_STORE: begin
        ok = (f3 <= 3'd2);
        e.mem.wr  = 1'b1;
        e.mem.adr = a + is;
        e.mem.wdt = b;
      end
      default: ok = 1'b0;  // incl. word ops on RV32
    endcase
    e.mem.f3  = f3;
    e.mem.vld = ok && (opc == OPC_LOAD || opc == OPC_STORE);
    e.wb.ill  = !ok;
    e.wb.we   = ok && alu && (e.wb.rd != 5'd0);
    return e;
  endfunction

  ////////////////////
  // compare
  ////////////////////

  task automatic report(input string name, input logic [63:0] e, input logic [63:0] g);
    n_mis++;
    $display("Mismatch at %0t: %s expected %0h received %0h", $time, name, e, g);
  endtask

  task automatic wb_compare(input wb_t e, input wb_t g);
    if (g.we !== e.we) report("wb.we", e.we, g.we);
    if (g.ill !== e.ill) report("wb.ill", e.ill, g.ill);
    if (g.rd !== e.rd) report("wb.rd", e.rd, g.rd);
    if (e.we && g.dat !== e.dat) report("wb.dat", e.dat, g.dat);  // dat only meant on writes
  endtask

  task automatic mem_compare(input mem_t e, input mem_t g);
    if (g.vld !== e.vld) report("mem.vld", e.vld, g.vld);
    if (e.vld) begin
      if (g.wr !== e.wr) report("mem.wr", e.wr, g.wr);
      if (g.f3 !== e.f3) report("mem.f3", e.f3, g.f3);
      if (g.adr !== e.adr) report("mem.adr", e.adr, g.adr);
      if (e.wr && g.wdt !== e.wdt) report("mem.wdt", e.wdt, g.wdt);
    end
  endtask

  // outputs settle after the rising edge, so look at the falling one
  always @(negedge clk) begin
    exp_t e;
    if (rst_n && wb.vld) begin
      if (exp_q.size() == 0) begin
        n_other++;
        $display("wb.vld at %0t with no instruction outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        if (cyc - e.cyc != 2) begin
          n_other++;
          $display("result at %0t came %0d cycles after issue, not 2", $time, cyc - e.cyc);
        end
        wb_compare(e.wb, wb);
        mem_compare(e.mem, mem);
      end
    end else if (rst_n && mem.vld) begin
      n_other++;
      $display("mem.vld at %0t without wb.vld", $time);
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic send(input logic [31:0] ins, input xlen_t pc, input xlen_t rs1,
                      input xlen_t rs2);
    @(negedge clk);
    iss.vld = 1'b1;
    iss.ins = ins;
    iss.pc  = pc;
    iss.rs1 = rs1;
    iss.rs2 = rs2;
    exp_q.push_back(predict(iss, cyc));
  endtask

  task automatic bubble();
    @(negedge clk);
    iss.vld = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] ins;
    logic [11:0] imm;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [3:0]  kind;
    iss     = '0;
    rst_n   = 1'b0;
    cyc     = 0;
    n_mis   = 0;
    n_other = 0;
    seed    = 32'h3db6;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) @(negedge clk);  // nothing may come out before the first issue

    // R-type on corner operands, sub and sra last
    for (int k = 0; k < 10; k++) begin
      for (int j = 0; j < 3; j++) begin
        send(r_word((k >= 8) ? 7'h20 : 7'h00, (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5),
                    5'(k + 1), OPC_OP), 0, opa[j], opb[j]);
      end
    end

    // immediates
    send(i_word(12'hfff, 3'd0, 5'd3, OPC_OP_IMM), 0, 32'h7fff_ffff, 0);  // addi -1
    send(i_word(12'h7ff, 3'd0, 5'd3, OPC_OP_IMM), 0, 32'h8000_0000, 0);
    send(i_word(12'hfff, 3'd2, 5'd4, OPC_OP_IMM), 0, 32'h8000_0000, 0);  // slti
    send(i_word(12'hfff, 3'd3, 5'd4, OPC_OP_IMM), 0, 32'hffff_fffe, 0);  // sltiu max
    send(i_word(12'hfff, 3'd4, 5'd5, OPC_OP_IMM), 0, 32'h1234_5678, 0);
    send(i_word(12'h800, 3'd6, 5'd5, OPC_OP_IMM), 0, 32'h0000_00ff, 0);
    send(i_word(12'h0f0, 3'd7, 5'd5, OPC_OP_IMM), 0, 32'hffff_ffff, 0);
    send(i_word(12'h01f, 3'd1, 5'd6, OPC_OP_IMM), 0, 32'hffff_ffff, 0);  // slli 31
    send(i_word(12'h01f, 3'd5, 5'd6, OPC_OP_IMM), 0, 32'h8000_0000, 0);  // srli 31
    send(i_word(12'h41f, 3'd5, 5'd6, OPC_OP_IMM), 0, 32'h8000_0000, 0);  // srai 31
    send(i_word(12'h400, 3'd5, 5'd6, OPC_OP_IMM), 0, 32'h8000_0000, 0);  // srai 0
    send(u_word(20'h80000, 5'd7), 32'h0000_1000, 0, 0);
    send(u_word(20'hfffff, 5'd8), 32'h0000_0ffc, 0, 0);  // wraps

    // loads and stores, negative offsets
    for (int k = 0; k < 5; k++) begin
      send(i_word(12'hffc, ld_f3[k], 5'd9, OPC_LOAD), 0, 32'h0000_2000, 32'hdead_beef);
    end
    for (int k = 0; k < 3; k++) begin
      send(s_word(12'h804, 3'(k)), 0, 32'h1000_0000, 32'hcafe_f00d);
    end

    // rd zero and illegal words
    send(r_word(7'h00, 3'd0, 5'd0, OPC_OP), 0, 5, 6);
    send(i_word(12'h001, 3'd0, 5'd0, OPC_OP_IMM), 0, 5, 6);
    send(32'h0000_0000, 0, 1, 2);
    send(32'hffff_ffff, 0, 1, 2);
    send(r_word(7'h00, 3'd0, 5'd3, OPC_OP_32), 0, 1, 2);   // word op on RV32
    send(r_word(7'h20, 3'd1, 5'd3, OPC_OP), 0, 1, 2);      // no sub form of sll
    send(i_word(12'h000, 3'd3, 5'd3, OPC_LOAD), 0, 1, 2);  // ld on RV32
    send(s_word(12'h000, 3'd4), 0, 1, 2);

    // back to back random issue
    repeat (N_RAND) begin
      r    = $random(seed);
      kind = r[3:0];
      f3   = r[6:4];
      rd   = r[11:7];
      imm  = r[23:12];
      case (kind)
        4'd0, 4'd1, 4'd2, 4'd3, 4'd4:
          ins = r_word((r[24] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, f3, rd, OPC_OP);
        4'd5, 4'd6, 4'd7, 4'd8: begin
          if (f3 == 3'd1) imm[11:5] = 7'h00;
          if (f3 == 3'd5) imm[11:5] = r[24] ? 7'h20 : 7'h00;
          ins = i_word(imm, f3, rd, OPC_OP_IMM);
        end
        4'd9: ins = u_word(r[31:12], rd);
        4'd10, 4'd11: ins = i_word(imm, (f3 == 3'd3 || f3 >= 3'd6) ? 3'd2 : f3, rd, OPC_LOAD);
        4'd12, 4'd13: ins = s_word(imm, (f3 > 3'd2) ? 3'd2 : f3);
        default: ins = $random(seed);  // mostly illegal
      endcase
      send(ins, $random(seed), $random(seed), $random(seed));
    end
    bubble();
    repeat (4) @(negedge clk);  // drain both stages

    if (exp_q.size() != 0) begin
      n_other++;
      $display("%0d results never came out", exp_q.size());
    end
    $display("errors: %0d mismatches, %0d other", n_mis, n_other);
    if (n_mis + n_other == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : r5p_exu_tb

// ==== tests/r5p_exu_props.sv ====
// output timing and exclusivity checks for the execute slice
// bound into r5p_exu by the testbench

`timescale 1ns/1ps

module r5p_exu_props import riscv_isa_pkg::*; (
  input logic clk,
  input logic rst_n,
  input iss_t iss,
  input wb_t  wb,
  input mem_t mem
);

  // two register stages, no stall
  a_wb_after_iss: assert property (@(posedge clk) disable iff (!rst_n)
    iss.vld |-> ##2 wb.vld)
    else $error("wb.vld missing two cycles after issue");

  a_wb_from_iss: assert property (@(posedge clk) disable iff (!rst_n)
    wb.vld |-> $past(iss.vld, 2))
    else $error("wb.vld without an issue two cycles earlier");

  a_we_legal: assert property (@(posedge clk) disable iff (!rst_n)
    wb.we |-> (!wb.ill && (wb.rd != 5'd0)))  // x0 never written
    else $error("wb.we on illegal instruction or rd zero");

  a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
    mem.vld |-> (wb.vld && !wb.we))
    else $error("mem.vld without wb.vld or together with wb.we");

  ////////////////////
  // reset
  ////////////////////

  a_rst_quiet: assert property (@(posedge clk)
    !rst_n |=> (!wb.vld && !wb.we && !mem.vld))
    else $error("output valid high during reset");

endmodule : r5p_exu_props

// ==== hw/r5p_exu.sv ====
// integer execute slice top
// issue -> decode -> stage -> ALU/result -> stages

`timescale 1ns/1ps

`include "r5p_macros.svh"

module r5p_exu import riscv_isa_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  iss_t iss,   // issue port, no stall
  output wb_t  wb,    // to register file
  output mem_t mem    // to data memory
);

  ctl_t               dec_ctl;
  exe_t               exe_d;
  exe_t               exe_q;
  logic               exe_vld;
  xlen_t              alu_rd;
  logic [`R5P_XLEN:0] alu_sum;
  wb_t                wb_d;
  wb_t                wb_q;
  logic               wb_vld;
  mem_t               mem_d;
  mem_t               mem_q;
  logic               mem_vld;

  ////////////////////
  // decode, cycle 0
  ////////////////////

  r5p_dec dec_i (
    .ins (iss.ins),
    .ctl (dec_ctl)
  );

  assign exe_d = '{ctl: dec_ctl, pc: iss.pc, rs1: iss.rs1, rs2: iss.rs2};

  r5p_stage #(.payload_t(exe_t)) exe_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld_in  (iss.vld),
    .dat_in  (exe_d),
    .vld_out (exe_vld),
    .dat_out (exe_q)
  );

  ////////////////////
  // execute, cycle 1
  ////////////////////

  r5p_alu #(.XLEN(`R5P_XLEN), .CFG_LSA(`R5P_CFG_LSA)) alu_i (
    .clk   (clk),
    .rst_n (rst_n),
    .ctl   (exe_q.ctl),
    .pc    (exe_q.pc),
    .rs1   (exe_q.rs1),
    .rs2   (exe_q.rs2),
    .rd    (alu_rd),
    .sum   (alu_sum)
  );

  r5p_res res_i (
    .ctl     (exe_q.ctl),
    .rs1     (exe_q.rs1),
    .rs2     (exe_q.rs2),
    .alu_rd  (alu_rd),
    .alu_sum (alu_sum),
    .wb      (wb_d),
    .mem     (mem_d)
  );

  r5p_stage #(.payload_t(wb_t)) wbs_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld_in  (exe_vld),                              // every instruction
    .dat_in  (wb_d),
    .vld_out (wb_vld),
    .dat_out (wb_q)
  );

  r5p_stage #(.payload_t(mem_t)) mems_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld_in  (exe_vld && (exe_q.ctl.ls != LS_NONE)),  // loads and stores only
    .dat_in  (mem_d),
    .vld_out (mem_vld),
    .dat_out (mem_q)
  );

  // stage valids qualify the unreset payload
  assign wb  = '{vld: wb_vld, we: wb_vld & wb_q.we, ill: wb_vld & wb_q.ill,
                 rd: wb_q.rd, dat: wb_q.dat};
  assign mem = '{vld: mem_vld, wr: mem_q.wr, f3: mem_q.f3,
                 adr: mem_q.adr, wdt: mem_q.wdt};

endmodule : r5p_exu

// ==== hw/r5p_res.sv ====
// result stage
// load/store address, writeback packet, memory request

`timescale 1ns/1ps

`include "r5p_macros.svh"

module r5p_res import riscv_isa_pkg::*; (
  input  ctl_t                ctl,
  input  xlen_t               rs1,
  input  xlen_t               rs2,
  input  xlen_t               alu_rd,
  input  logic [`R5P_XLEN:0]  alu_sum,
  output wb_t                 wb,
  output mem_t                mem
);

  xlen_t adr;

  ////////////////////
  // address
  ////////////////////

  if (`R5P_CFG_LSA) begin : gen_lsa
    xlen_t ofs;
    assign ofs = (ctl.ls == LS_STORE) ? ctl.imm.s : ctl.imm.l;
    assign adr = rs1 + ofs;  // dedicated adder, ALU stays off the path
  end else begin : gen_alu
    assign adr = alu_sum[`R5P_XLEN-1:0];  // carry bit dropped
  end

  ////////////////////
  // outputs
  ////////////////////

  // valids come from the stage registers
  assign wb.vld = 1'b0;
  assign wb.we  = ctl.we && !ctl.ill && (ctl.ls == LS_NONE) && (ctl.rd != 5'd0);
  assign wb.ill = ctl.ill;
  assign wb.rd  = ctl.rd;
  assign wb.dat = alu_rd;

  assign mem.vld = 1'b0;
  assign mem.wr  = (ctl.ls == LS_STORE);
  assign mem.f3  = ctl.f3;
  assign mem.adr = adr;
  assign mem.wdt = rs2;  // store data, ignored on loads

endmodule : r5p_res

// ==== hw/r5p_alu.sv ====
// arithmetic/logic unit
// input mux, shared adder, barrel shifter, word result handling

`timescale 1ns/1ps

`include "r5p_macros.svh"

module r5p_alu import riscv_isa_pkg::*; #(
  parameter int unsigned XLEN    = `R5P_XLEN,
  parameter bit          CFG_LSA = `R5P_CFG_LSA  // addresses formed outside the ALU
)(
  input  logic          clk,    // purely combinational block
  input  logic          rst_n,
  input  ctl_t          ctl,
  input  xlen_t         pc,
  input  xlen_t         rs1,
  input  xlen_t         rs2,
  output xlen_t         rd,
  output logic [XLEN:0] sum     // includes carry/borrow bit
);

  localparam int unsigned XLOG = $clog2(XLEN);

  logic [XLEN-1:0] in1;  // muxed inputs
  logic [XLEN-1:0] in2;
  logic [XLEN:0]   op1;  // extended by one bit
  logic [XLEN:0]   op2;
  logic            inv;  // subtract / compare
  logic            wrd;  // word operation
  logic [XLOG-1:0] sam;  // raw shift amount
  logic [XLOG-1:0] sa;
  logic [XLEN-1:0] shw;  // word shift operand
  logic [XLEN-1:0] shi;
  logic [XLEN-1:0] val;

  ////////////////////
  // input mux
  ////////////////////

  always_comb begin
    in1 = rs1;
    in2 = rs2;
    case (ctl.ai)
      AI_R1_R2: ;                                      // R-type
      AI_R1_II: in2 = ctl.imm.i;                       // I-type arithmetic
      AI_R1_IL: in2 = CFG_LSA ? rs2 : ctl.imm.l;       // load address
      AI_R1_IS: in2 = CFG_LSA ? rs2 : ctl.imm.s;       // store address
      AI_PC_IU: begin                                  // auipc
        in1 = pc;
        in2 = ctl.imm.u;
      end
      default: begin
        in1 = 'x;
        in2 = 'x;
      end
    endcase
  end

  assign wrd = (ctl.rt == R_SW) || (ctl.rt == R_UW);

  ////////////////////
  // adder
  ////////////////////

  // signed/unsigned extension to XLEN+1
  always_comb begin
    case (ctl.rt)
      R_SX: begin
        op1 = (XLEN+1)'(signed'(in1));
        op2 = (XLEN+1)'(signed'(in2));
      end
      R_UX: begin
        op1 = (XLEN+1)'(in1);
        op2 = (XLEN+1)'(in2);
      end
      R_SW: begin
        op1 = (XLEN+1)'(signed'(in1[31:0]));
        op2 = (XLEN+1)'(signed'(in2[31:0]));
      end
      default: begin                              // unsigned word
        op1 = (XLEN+1)'(in1[31:0]);
        op2 = (XLEN+1)'(in2[31:0]);
      end
    endcase
  end

  assign inv = (ctl.ao == AO_SUB) || (ctl.ao == AO_SLT) || (ctl.ao == AO_SLTU);

  // a - b as a + ~b + 1, msb gives the compare result
  assign sum = op1 + (inv ? ~op2 : op2) + (XLEN+1)'(inv);

  ////////////////////
  // shifter
  ////////////////////

  assign sam = (ctl.ai == AI_R1_R2) ? rs2[XLOG-1:0] : ctl.imm.i[XLOG-1:0];
  assign sa  = wrd ? XLOG'(sam[4:0]) : sam;  // word shifts use 5 bits

  // word shifts see only the low word, sign or zero filled
  assign shw = (ctl.ao == AO_SRA) ? XLEN'(signed'(in1[31:0])) : XLEN'(in1[31:0]);
  assign shi = wrd ? shw : in1;

  ////////////////////
  // output mux
  ////////////////////

  always_comb begin
    case (ctl.ao)
      AO_ADD,
      AO_SUB:  val = sum[XLEN-1:0];
      AO_SLT,
      AO_SLTU: val = XLEN'(sum[XLEN]);
      AO_AND:  val = in1 & in2;
      AO_OR:   val = in1 | in2;
      AO_XOR:  val = in1 ^ in2;
      AO_SRA:  val = $signed(shi) >>> sa;
      AO_SRL:  val = shi >> sa;
      AO_SLL:  val = shi << sa;
      default: val = 'x;
    endcase
  end

  // word results are sign extended regardless of op
  assign rd = wrd ? XLEN'(signed'(val[31:0])) : val;

endmodule : r5p_alu

// ==== hw/r5p_dec.sv ====
// instruction decoder, RV32I/RV64I integer subset
// builds the control structure and the illegal flag

`timescale 1ns/1ps

`include "r5p_macros.svh"

module r5p_dec import riscv_isa_pkg::*; (
  input  logic [31:0] ins,
  output ctl_t        ctl
);

  localparam int unsigned DXLEN = `R5P_XLEN;
  localparam bit          RV64  = (DXLEN == 64);

  opc_t       opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [6:0] fs;   // funct7 view of shift immediates
  imm_t       imm;

  assign opc = opc_t'(ins[6:0]);
  assign f3  = ins[14:12];
  assign f7  = ins[31:25];
  assign fs  = RV64 ? {ins[31:26], 1'b0} : ins[31:25];  // bit 25 is shamt[5] on RV64

  ////////////////////
  // immediates
  ////////////////////

  assign imm.i = DXLEN'(signed'(ins[31:20]));
  assign imm.l = DXLEN'(signed'(ins[31:20]));
  assign imm.s = DXLEN'(signed'({ins[31:25], ins[11:7]}));
  assign imm.u = DXLEN'(signed'({ins[31:12], 12'h000}));  // sign extends on RV64

  ////////////////////
  // control
  ////////////////////

  always_comb begin
    // defaults, a harmless add
    ctl     = '0;
    ctl.ai  = AI_R1_R2;
    ctl.ao  = AO_ADD;
    ctl.rt  = R_SX;
    ctl.imm = imm;
    ctl.rd  = ins[11:7];
    ctl.f3  = f3;
    ctl.ls  = LS_NONE;
    case (opc)
      OPC_OP: begin
        ctl.ao  = alu_ao_t'({f7[5], f3});
        ctl.rt  = (f3 == 3'b011) ? R_UX : R_SX;  // sltu compares unsigned
        ctl.we  = 1'b1;
        ctl.ill = !((f7 == 7'b0000000) ||
                    (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)));
      end
      OPC_OP_IMM: begin
        ctl.ai  = AI_R1_II;
        ctl.ao  = alu_ao_t'({(f3 == 3'b101) & fs[5], f3});  // no subi
        ctl.rt  = (f3 == 3'b011) ? R_UX : R_SX;
        ctl.we  = 1'b1;
        case (f3)
          3'b001:  ctl.ill = (fs != 7'b0000000);
          3'b101:  ctl.ill = !(fs == 7'b0000000 || fs == 7'b0100000);
          default: ctl.ill = 1'b0;
        endcase
      end
      OPC_OP_32: begin
        ctl.ao  = alu_ao_t'({f7[5], f3});
        ctl.rt  = R_SW;
        ctl.we  = 1'b1;
        ctl.ill = !RV64 ||
                  !((f7 == 7'b0000000 && (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101)) ||
                    (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)));
      end
      OPC_OP_IMM_32: begin
        ctl.ai  = AI_R1_II;
        ctl.ao  = alu_ao_t'({(f3 == 3'b101) & f7[5], f3});
        ctl.rt  = R_SW;
        ctl.we  = 1'b1;
        ctl.ill = !RV64 ||
                  !((f3 == 3'b000) ||
                    (f3 == 3'b001 && f7 == 7'b0000000) ||
                    (f3 == 3'b101 && (f7 == 7'b0000000 || f7 == 7'b0100000)));
      end
      OPC_AUIPC: begin
        ctl.ai = AI_PC_IU;
        ctl.we = 1'b1;
      end
      OPC_LOAD: begin
        ctl.ai  = `R5P_CFG_LSA ? AI_R1_R2 : AI_R1_IL;  // don't care with lsa
        ctl.ls  = LS_LOAD;
        ctl.ill = !((f3 != 3'b011 && f3 != 3'b110 && f3 != 3'b111) ||
                    (RV64 && (f3 == 3'b011 || f3 == 3'b110)));  // ld, lwu
      end
      OPC_STORE: begin
        ctl.ai  = `R5P_CFG_LSA ? AI_R1_R2 : AI_R1_IS;
        ctl.ls  = LS_STORE;
        ctl.ill = f3[2] || (f3 == 3'b011 && !RV64);  // sd on RV64 only
      end
      default: ctl.ill = 1'b1;
    endcase
    // illegal never writes and never touches memory
    if (ctl.ill) begin
      ctl.we = 1'b0;
      ctl.ls = LS_NONE;
    end
  end

endmodule : r5p_dec

// ==== hw/r5p_stage.sv ====
// valid qualified pipeline register
// payload type set by parameter

`timescale 1ns/1ps

module r5p_stage #(
  parameter type payload_t = logic
)(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     vld_in,
  input  payload_t dat_in,
  output logic     vld_out,
  output payload_t dat_out
);

  // valid is the only control state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_out <= 1'b0;
    end else begin
      vld_out <= vld_in;
    end
  end

  // payload follows valid, holds otherwise
  always_ff @(posedge clk) begin
    if (vld_in) begin
      dat_out <= dat_in;
    end
  end

endmodule : r5p_stage

// ==== hw/riscv_isa_pkg.sv ====
// RV32I/RV64I opcodes, ALU selector encodings
// immediate, control and pipeline packet types

`include "r5p_macros.svh"

package riscv_isa_pkg;

  localparam int unsigned XLEN = `R5P_XLEN;

  typedef logic [XLEN-1:0] xlen_t;  // register wide value

  ////////////////////
  // opcodes
  ////////////////////

  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,  // RV64 only
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_OP_32     = 7'b0111011   // RV64 only
  } opc_t;

  ////////////////////
  // ALU selectors
  ////////////////////

  // input operand pairs
  typedef enum logic [2:0] {
    AI_R1_R2 = 3'd0,  // R-type
    AI_R1_II = 3'd1,  // I-type arithmetic
    AI_R1_IL = 3'd2,  // I-type load
    AI_R1_IS = 3'd3,  // S-type store
    AI_PC_IU = 3'd4   // U-type, auipc
  } alu_ai_t;

  // operation, encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    AO_ADD  = 4'b0000,
    AO_SUB  = 4'b1000,
    AO_SLL  = 4'b0001,
    AO_SLT  = 4'b0010,
    AO_SLTU = 4'b0011,
    AO_XOR  = 4'b0100,
    AO_SRL  = 4'b0101,
    AO_SRA  = 4'b1101,
    AO_OR   = 4'b0110,
    AO_AND  = 4'b0111
  } alu_ao_t;

  // result extension
  typedef enum logic [1:0] {
    R_SX = 2'b00,  // signed XLEN
    R_UX = 2'b01,  // unsigned XLEN
    R_SW = 2'b10,  // signed word
    R_UW = 2'b11   // unsigned word
  } alu_rt_t;

  // memory access kind
  typedef enum logic [1:0] {
    LS_NONE  = 2'd0,
    LS_LOAD  = 2'd1,
    LS_STORE = 2'd2
  } ls_t;

  ////////////////////
  // decoder output
  ////////////////////

  // immediates, all sign extended to XLEN
  typedef struct packed {
    xlen_t i;  // arithmetic
    xlen_t l;  // load
    xlen_t s;  // store
    xlen_t u;  // upper
  } imm_t;

  typedef struct packed {
    alu_ai_t    ai;
    alu_ao_t    ao;
    alu_rt_t    rt;
    imm_t       imm;
    logic [4:0] rd;   // destination index
    logic       we;   // register write enable
    ls_t        ls;
    logic [2:0] f3;   // access size for load/store
    logic       ill;  // illegal encoding
  } ctl_t;

  ////////////////////
  // pipeline packets
  ////////////////////

  typedef struct packed {
    logic        vld;
    logic [31:0] ins;
    xlen_t       pc;
    xlen_t       rs1;
    xlen_t       rs2;
  } iss_t;

  typedef struct packed {
    ctl_t  ctl;
    xlen_t pc;
    xlen_t rs1;
    xlen_t rs2;
  } exe_t;

  typedef struct packed {
    logic       vld;
    logic       we;
    logic       ill;
    logic [4:0] rd;
    xlen_t      dat;
  } wb_t;

  typedef struct packed {
    logic       vld;
    logic       wr;   // store
    logic [2:0] f3;   // size and sign
    xlen_t      adr;
    xlen_t      wdt;  // store data
  } mem_t;

endpackage : riscv_isa_pkg

// ==== hw/r5p_macros.svh ====
// datapath width and load/store adder option
// shared by the package and the RTL

`ifndef R5P_MACROS_SVH
`define R5P_MACROS_SVH

////////////////////
// datapath
////////////////////

// register width, 32 (RV32I) or 64 (RV64I)
`define R5P_XLEN 32

////////////////////
// timing vs area
////////////////////

// 1: load/store address from result stage adder
// 0: load/store address from ALU adder
`define R5P_CFG_LSA 1'b1

`endif
